// ==== common/decode_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// widths are fixed by the LA32 encoding; the class vector is one-hot except
// that ll/sc also set the memory bit and preld also sets the memory bit
////////////////////////////////////////////////////////////////////////////
package decode_pkg;

    typedef logic [13:0] ins_class_t;   // one bit per instruction class
    typedef logic [4:0]  reg_idx_t;     // gpr number
    typedef logic [31:0] word_t;        // data / instruction word
    typedef logic [1:0]  src1_sel_t;
    typedef logic [1:0]  src2_sel_t;
    typedef logic [3:0]  cond_t;        // alu op, br cond, mem size/store, mul/div variant
    typedef logic [2:0]  exc_code_t;

    // class bit positions
    localparam int cls_br      = 0;
    localparam int cls_bar     = 1;     // ibar / dbar
    localparam int cls_mem     = 2;
    localparam int cls_preload = 3;
    localparam int cls_csr     = 4;
    localparam int cls_cache   = 5;     // cacop
    localparam int cls_idle    = 6;
    localparam int cls_ertn    = 7;
    localparam int cls_tlb     = 8;
    localparam int cls_ecall   = 9;     // syscall / break
    localparam int cls_mul     = 10;
    localparam int cls_div     = 11;
    localparam int cls_alu     = 12;
    localparam int cls_scll    = 13;

    localparam src1_sel_t src1_rf    = 2'd0;
    localparam src1_sel_t src1_zero  = 2'd1;
    localparam src1_sel_t src1_pc    = 2'd2;
    localparam src1_sel_t src1_cntid = 2'd3;

    localparam src2_sel_t src2_rf    = 2'd0;
    localparam src2_sel_t src2_imm   = 2'd1;
    localparam src2_sel_t src2_cntl  = 2'd2;   // stable counter low
    localparam src2_sel_t src2_cnth  = 2'd3;   // stable counter high

    // alu ops, same as inst[18:15] of the 3-register form
    localparam cond_t alu_add  = 4'b0000;
    localparam cond_t alu_sub  = 4'b0010;
    localparam cond_t alu_slt  = 4'b0100;
    localparam cond_t alu_sltu = 4'b0101;
    localparam cond_t alu_nor  = 4'b1000;
    localparam cond_t alu_and  = 4'b1001;
    localparam cond_t alu_or   = 4'b1010;
    localparam cond_t alu_xor  = 4'b1011;
    localparam cond_t alu_sra  = 4'b1100;   // no slot in the reg form
    localparam cond_t alu_sll  = 4'b1110;
    localparam cond_t alu_srl  = 4'b1111;

    localparam exc_code_t exc_none    = 3'd0;
    localparam exc_code_t exc_syscall = 3'd1;
    localparam exc_code_t exc_break   = 3'd2;
    localparam exc_code_t exc_ine     = 3'd3;   // instruction not exist
    localparam exc_code_t exc_ipe     = 3'd4;   // privilege error

    typedef struct packed {
        ins_class_t cls;
        src1_sel_t  src1;
        src2_sel_t  src2;
        cond_t      cond;
        logic       sign;       // signed mul/div or sign-extending load
        logic       mem_atm;    // ll / sc
        logic       priv;       // privileged class, cacop hit included
    } uop_t;

    typedef struct packed {
        uop_t     uop;
        word_t    imm;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        logic     is_alu;
    } decoded_t;

    typedef struct packed {
        decoded_t  dec;
        exc_code_t exc;
    } id_out_t;

endpackage

// ==== decode/inst_decoder.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// combinational, LA32 subset only; float branches and 64-bit ops are invalid
// stores and branch compares carry their rd field on rk, rd is then r0
////////////////////////////////////////////////////////////////////////////
module inst_decoder import decode_pkg::*; (
    input  word_t    inst,
    output decoded_t dec,
    output logic     is_syscall,
    output logic     is_break,
    output logic     is_privileged,
    output logic     invalid
);

    ins_class_t cls;
    logic       is_b_or_bl;
    logic       is_jirl;
    logic       is_bl;
    logic       is_pcadd;
    logic       is_lui;
    logic       is_alu_imm;
    logic       is_alu_reg;
    logic       is_alu_sfti;
    logic       is_sra;
    logic       is_time;
    logic       is_invtlb;
    logic       is_store;
    logic       mem_atm;
    logic       no_rd;
    cond_t      alu_op;
    logic       alu_bad;
    logic       br_bad;
    cond_t      cond;

    //////////////////////////////////////////////////////////////////////////
    // opcode matching
    assign is_b_or_bl  = inst[30:27] == 4'b1010;
    assign is_jirl     = inst[30:26] == 5'b10011;
    assign is_bl       = inst[30:26] == 5'b10101;     // links to r1
    assign is_pcadd    = inst[30:25] == 6'b001110;
    assign is_lui      = inst[30:25] == 6'b001010;
    assign is_alu_imm  = inst[30:25] == 6'b000001;    // slti..xori
    assign is_alu_reg  = inst[30:19] == 12'b000000000010;
    assign is_alu_sfti = inst[30:20] == 11'b00000000100 && inst[17:15] == 3'b001;
    assign is_sra      = inst[30:15] == 16'b0000000000110000;
    assign is_time     = inst[30:11] == 20'b00000000000000001100;  // rdcnt*
    assign is_invtlb   = inst[30:15] == 16'b0000110010010011;

    assign cls[cls_br]      = inst[30];
    assign cls[cls_bar]     = inst[30:16] == 15'b011100001110010;
    assign cls[cls_mem]     = inst[30:28] == 3'b010;
    assign cls[cls_preload] = inst[30:22] == 9'b010101011;
    assign cls[cls_csr]     = inst[30:24] == 7'b0000100;
    assign cls[cls_cache]   = inst[30:22] == 9'b000011000;
    assign cls[cls_idle]    = inst[30:15] == 16'b0000110010010001;
    assign cls[cls_ertn]    = inst[30:10] == 21'b000011001001000001110;
    // tlbsrch/rd/wr/fill sit at 12:10 = 2..5, ertn takes 6
    assign cls[cls_tlb]     = is_invtlb || (inst[30:13] == 18'b000011001001000001 &&
                              inst[12:10] >= 3'b010 && inst[12:10] <= 3'b101);
    assign cls[cls_ecall]   = inst[30:17] == 14'b00000000010101 && !inst[15];
    assign cls[cls_mul]     = inst[30:17] == 14'b00000000001110;
    assign cls[cls_div]     = inst[30:17] == 14'b00000000010000;
    assign cls[cls_alu]     = is_alu_reg | is_alu_imm | is_alu_sfti | is_sra |
                              is_time | is_pcadd | is_lui;
    assign cls[cls_scll]    = inst[30:25] == 6'b010000;

    assign is_syscall = cls[cls_ecall] & inst[16];
    assign is_break   = cls[cls_ecall] & ~inst[16];
    assign is_store   = cls[cls_mem] & inst[24];
    assign mem_atm    = cls[cls_mem] & ~inst[27];     // ll / sc

    //////////////////////////////////////////////////////////////////////////
    // sub-codes
    always_comb begin
        alu_op  = alu_add;                  // lu12i and pcaddu12i add too
        alu_bad = 1'b0;
        if (is_alu_reg) begin
            alu_op = inst[18:15];
            case (inst[18:15])
                4'b0001, 4'b0011, 4'b0110, 4'b0111, 4'b1100, 4'b1101: alu_bad = 1'b1;
                default: ;
            endcase
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000:  alu_op = alu_slt;
                3'b001:  alu_op = alu_sltu;
                3'b010:  alu_op = alu_add;
                3'b101:  alu_op = alu_and;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_xor;
                default: alu_bad = 1'b1;    // 64-bit or unused slots
            endcase
        end else if (is_alu_sfti) begin
            case (inst[19:18])
                2'b00:   alu_op = alu_sll;
                2'b01:   alu_op = alu_srl;
                2'b10:   alu_op = alu_sra;
                default: alu_bad = 1'b1;
            endcase
        end else if (is_sra) begin
            alu_op = alu_sra;
        end
    end

    // jirl..bgeu are 0011..1011, bceqz/bcnez fall outside
    assign br_bad = cls[cls_br] && (inst[29:26] < 4'b0011 || inst[29:26] > 4'b1011);

    always_comb begin
        cond = '0;
        if (cls[cls_alu])
            cond = alu_op;
        else if (cls[cls_br])
            cond = inst[29:26];             // raw branch opcode
        else if (cls[cls_mem])
            cond = {1'b0, inst[24], inst[27] ? inst[23:22] : 2'b10};  // atomics are word
        else if (cls[cls_mul])
            cond = {3'b0, inst[15] | inst[16]};   // high half
        else if (cls[cls_div])
            cond = {3'b0, inst[15]};              // 1 = mod
    end

    assign invalid = inst[31] | (cls == '0) | alu_bad | br_bad |
                     (is_invtlb && inst[4:0] > 5'd6);

    // hit-type cacop (code 2) runs at user level
    assign is_privileged = (cls[cls_cache] && inst[4:3] != 2'd2) | cls[cls_tlb] |
                           cls[cls_csr] | cls[cls_ertn] | cls[cls_idle];

    //////////////////////////////////////////////////////////////////////////
    // bundle
    assign dec.uop.cls  = cls;
    assign dec.uop.src1 = is_lui   ? src1_zero :
                          is_pcadd ? src1_pc   :
                          (is_time && !inst[10] && inst[4:0] == '0) ? src1_cntid :
                          src1_rf;
    assign dec.uop.src2 = (is_alu_imm | is_alu_sfti | is_lui | is_pcadd) ? src2_imm :
                          !is_time ? src2_rf :
                          (!inst[10] && inst[4:0] != '0) ? src2_cntl : src2_cnth;
    assign dec.uop.cond    = cond;
    assign dec.uop.sign    = ((cls[cls_mul] | cls[cls_div]) & ~inst[16]) |
                             (cls[cls_mem] & ~inst[25]);
    assign dec.uop.mem_atm = mem_atm;
    assign dec.uop.priv    = cls[cls_cache] | cls[cls_tlb] | cls[cls_csr] |
                             cls[cls_ertn] | cls[cls_idle] | cls[cls_bar];
    assign dec.is_alu      = cls[cls_alu];

    // instructions with no result write r0
    assign no_rd = cls[cls_cache] | cls[cls_tlb] | cls[cls_idle] | cls[cls_preload] |
                   cls[cls_bar] | cls[cls_ertn] | cls[cls_ecall] |
                   (is_store & ~mem_atm) | (cls[cls_br] & ~is_jirl & ~is_bl);
    assign dec.rd = no_rd ? '0 :
                    is_bl ? 5'd1 :
                    inst[4:0] | ({5{is_time}} & inst[9:5]);    // rdcntid dest in rj slot
    assign dec.rj = ((cls[cls_tlb] & ~is_invtlb) | cls[cls_idle] | cls[cls_bar] |
                     cls[cls_ecall] | is_pcadd | is_lui | is_b_or_bl | is_time) ?
                    '0 : inst[9:5];
    assign dec.rk = (is_alu_reg | is_sra | cls[cls_mul] | cls[cls_div] | is_invtlb) ?
                    inst[14:10] :
                    (is_store | (cls[cls_br] & ~is_b_or_bl & ~is_jirl) | cls[cls_csr]) ?
                    inst[4:0] : '0;

    // one format per class, the masks never overlap
    assign dec.imm =
        ({{20{inst[21]}}, inst[21:10]} & {32{cls[cls_cache] |
            (is_alu_imm & ~inst[24]) | (cls[cls_mem] & inst[27]) | is_alu_sfti}}) |
        ({20'b0, inst[21:10]} & {32{is_alu_imm & inst[24]}}) |       // u12 logic ops
        ({{18{inst[23]}}, inst[23:10]} & {32{cls[cls_csr]}}) |
        ({{16{inst[23]}}, inst[23:10], 2'b0} & {32{mem_atm}}) |     // ll/sc offset
        ({{16{inst[25]}}, inst[25:10]} & {32{cls[cls_br] & ~is_b_or_bl}}) |
        ({{6{inst[9]}}, inst[9:0], inst[25:10]} & {32{is_b_or_bl}}) |
        ({inst[24:5], 12'b0} & {32{is_pcadd | is_lui}});

endmodule

// ==== decode/id_stage.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// one cycle latency, no stall; a strobe may come every cycle
////////////////////////////////////////////////////////////////////////////
module id_stage import decode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       inst_valid,
    input  word_t      inst,
    input  logic [1:0] plv,
    output logic       out_valid,
    output id_out_t    out
);

    localparam logic [1:0] plv_user = 2'd3;

    decoded_t  dec;
    logic      is_syscall;
    logic      is_break;
    logic      is_privileged;
    logic      invalid;
    exc_code_t exc;

    inst_decoder u_decoder (
        .inst          (inst),
        .dec           (dec),
        .is_syscall    (is_syscall),
        .is_break      (is_break),
        .is_privileged (is_privileged),
        .invalid       (invalid)
    );

    // exception priority, highest first
    always_comb begin
        if (invalid)
            exc = exc_ine;
        else if (is_privileged && plv == plv_user)
            exc = exc_ipe;          // csr/tlb/ertn/idle at user level
        else if (is_syscall)
            exc = exc_syscall;
        else if (is_break)
            exc = exc_break;
        else
            exc = exc_none;
    end

    //////////////////////////////////////////////////////////////////////////
    // stage register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= inst_valid;        // single-cycle strobe, one behind
            if (inst_valid) begin
                out.dec <= dec;
                out.exc <= exc;
            end
        end
    end

endmodule

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// r0 reads zero and ignores writes; same-cycle write is bypassed to reads
////////////////////////////////////////////////////////////////////////////
module reg_file import decode_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_addr_a,
    input  reg_idx_t rd_addr_b,
    output word_t    rd_data_a,
    output word_t    rd_data_b,
    input  logic     wb_valid,
    input  reg_idx_t wb_rd,
    input  word_t    wb_data
);

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_valid && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // shared by both read ports
    function automatic word_t read_port(input reg_idx_t addr);
        word_t val;
        if (addr == '0)
            val = '0;
        else if (wb_valid && wb_rd == addr)
            val = wb_data;          // bypass, not yet in the array
        else
            val = regs[addr];
        return val;
    endfunction

    always_comb rd_data_a = read_port(rd_addr_a);
    always_comb rd_data_b = read_port(rd_addr_b);

endmodule

// ==== rtl/decode_top.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// no back-pressure; the consumer takes every out_valid
////////////////////////////////////////////////////////////////////////////
module decode_top import decode_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       inst_valid,
    input  word_t      inst,
    input  logic [1:0] plv,
    input  logic       wb_valid,
    input  reg_idx_t   wb_rd,
    input  word_t      wb_data,
    output logic       out_valid,
    output id_out_t    out,
    output word_t      rj_data,
    output word_t      rk_data
);

    id_stage u_id_stage (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .plv        (plv),
        .out_valid  (out_valid),
        .out        (out)
    );

    // operands read with the registered rj/rk, so they leave with the bundle
    reg_file u_reg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_addr_a (out.dec.rj),
        .rd_addr_b (out.dec.rk),
        .rd_data_a (rj_data),
        .rd_data_b (rk_data),
        .wb_valid  (wb_valid),
        .wb_rd     (wb_rd),
        .wb_data   (wb_data)
    );

endmodule

// ==== testbench/decode_properties.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// bound to id_stage and reg_file; inputs a target lacks are tied off
////////////////////////////////////////////////////////////////////////////
module decode_properties import decode_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     strobe_in,      // inst_valid
    input logic     strobe_out,     // out_valid
    input reg_idx_t addr_a,
    input reg_idx_t addr_b,
    input word_t    data_a,
    input word_t    data_b
);

    a_strobe_follows: assert property (@(posedge clk) disable iff (!rst_n)
        strobe_in |=> strobe_out) else $error("out_valid missing after inst_valid");
    a_strobe_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !strobe_in |=> !strobe_out) else $error("out_valid without inst_valid");
    a_reset_low: assert property (@(posedge clk)
        !rst_n |-> !strobe_out) else $error("out_valid high during reset");

    // r0 reads zero on both ports
    a_r0_a: assert property (@(posedge clk) addr_a == '0 |-> data_a == '0)
        else $error("port a read nonzero from r0");
    a_r0_b: assert property (@(posedge clk) addr_b == '0 |-> data_b == '0)
        else $error("port b read nonzero from r0");

endmodule

bind id_stage decode_properties u_stage_props (
    .clk(clk), .rst_n(rst_n), .strobe_in(inst_valid), .strobe_out(out_valid),
    .addr_a(5'd1), .addr_b(5'd1), .data_a(32'd0), .data_b(32'd0));

bind reg_file decode_properties u_rf_props (
    .clk(clk), .rst_n(rst_n), .strobe_in(1'b0), .strobe_out(1'b0),
    .addr_a(rd_addr_a), .addr_b(rd_addr_b), .data_a(rd_data_a), .data_b(rd_data_b));

// ==== testbench/tb_decode_top.sv ====
`timescale 1ns/1ps
////////////////////////////////////////////////////////////////////////////
// one trace record per clock with results sampled on the falling edge
// trace path is relative to the project root
////////////////////////////////////////////////////////////////////////////
module tb_decode_top import decode_pkg::*; ();

    typedef struct packed {
        uop_t      uop;
        word_t     imm;
        reg_idx_t  rd;
        reg_idx_t  rj;
        reg_idx_t  rk;
        exc_code_t exc;
        word_t     rj_data;
        word_t     rk_data;
    } expect_t;

    logic       clk;
    logic       rst_n;
    logic       inst_valid;
    word_t      inst;
    logic [1:0] plv;
    logic       wb_valid;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    logic       out_valid;
    id_out_t    out;
    word_t      rj_data;
    word_t      rk_data;

    expect_t exp_q[$];      // in issue order
    string   name_q[$];
    int      idle_cycles;   // cycles waited for the oldest pending result

    decode_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // compare tasks

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_uop(input string name, input uop_t exp, input uop_t act);
        if (act !== exp) begin
            $display("error %s uop: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(input string name, input string what, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            $display("error %s %s: expected %h, actual %h", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input string what, input reg_idx_t exp,
                             input reg_idx_t act);
        if (act !== exp) begin
            $display("error %s %s: expected r%0d, actual r%0d", name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_t exp, input exc_code_t act);
        if (act !== exp) begin
            $display("error %s exc: expected %0d, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s is_alu: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // oldest pending result is compared on each out_valid
    task automatic score_output();
        expect_t e;
        string   name;
        if (out_valid) begin
            if (exp_q.size() == 0) begin
                $display("out_valid came with no instruction pending");
                abort_run();
            end
            e = exp_q.pop_front();
            name = name_q.pop_front();
            idle_cycles = 0;
            check_uop(name, e.uop, out.dec.uop);
            check_word(name, "imm", e.imm, out.dec.imm);
            check_reg(name, "rd", e.rd, out.dec.rd);
            check_reg(name, "rj", e.rj, out.dec.rj);
            check_reg(name, "rk", e.rk, out.dec.rk);
            check_flag(name, e.uop.cls[cls_alu], out.dec.is_alu);   // alu class bit
            check_exc(name, e.exc, out.exc);
            check_word(name, "rj_data", e.rj_data, rj_data);
            check_word(name, "rk_data", e.rk_data, rk_data);
        end else if (exp_q.size() != 0) begin
            idle_cycles++;
            if (idle_cycles > 10) begin
                $display("timeout: no out_valid within 10 cycles for %s", name_q[0]);
                abort_run();
            end
        end
    endtask

    // drive 1 ns after the edge and sample at the falling edge
    task automatic run_cycle(input logic iv, input word_t iw, input logic [1:0] pl,
                             input logic wv, input reg_idx_t wr, input word_t wd);
        @(posedge clk);
        #1;
        inst_valid = iv;
        inst       = iw;
        plv        = pl;
        wb_valid   = wv;
        wb_rd      = wr;
        wb_data    = wd;
        @(negedge clk);
        score_output();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // trace replay
    initial begin
        int         fd;
        int         count;
        int         drain;
        byte        kind;
        string      line;
        string      name;
        word_t      t_inst, t_imm, t_data, t_rjd, t_rkd;
        logic [1:0] t_plv;
        ins_class_t t_cls;
        src1_sel_t  t_src1;
        src2_sel_t  t_src2;
        cond_t      t_cond;
        logic       t_sign, t_atm, t_priv;
        reg_idx_t   t_rd, t_rj, t_rk;
        exc_code_t  t_exc;
        inst_valid  = 1'b0;
        inst        = '0;
        plv         = 2'd0;
        wb_valid    = 1'b0;
        wb_rd       = '0;
        wb_data     = '0;
        idle_cycles = 0;
        rst_n       = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;

        fd = $fopen("testbench/decode_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file");
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            kind = line.getc(0);
            if (kind == "W") begin
                count = $sscanf(line, "W %h %h", t_rd, t_data);
                if (count != 2) begin
                    $display("malformed writeback record: %s", line);
                    abort_run();
                end
                run_cycle(1'b0, inst, plv, 1'b1, t_rd, t_data);
            end else if (kind == "D") begin
                count = $sscanf(line, "D %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                name, t_inst, t_plv, t_cls, t_src1, t_src2, t_cond, t_sign,
                                t_atm, t_priv, t_imm, t_rd, t_rj, t_rk, t_exc, t_rjd, t_rkd);
                if (count != 17) begin
                    $display("malformed decode record: %s", line);
                    abort_run();
                end
                exp_q.push_back({t_cls, t_src1, t_src2, t_cond, t_sign, t_atm, t_priv,
                                 t_imm, t_rd, t_rj, t_rk, t_exc, t_rjd, t_rkd});
                name_q.push_back(name);
                run_cycle(1'b1, t_inst, t_plv, 1'b0, wb_rd, wb_data);
            end
        end
        $fclose(fd);

        // let the last results come out
        drain = 0;
        while (exp_q.size() != 0 && drain < 12) begin
            run_cycle(1'b0, inst, plv, 1'b0, wb_rd, wb_data);
            drain++;
        end
        if (exp_q.size() != 0) begin
            $display("results still pending after the trace ended");
            abort_run();
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== build.f ====
common/decode_pkg.sv
decode/inst_decoder.sv
decode/id_stage.sv
rtl/reg_file.sv
rtl/decode_top.sv
testbench/decode_properties.sv
testbench/tb_decode_top.sv

// ==== testbench/decode_trace.txt ====
# W rd data | D name inst plv cls src1 src2 cond sign atm priv imm rd rj rk exc rj_data rk_data
# all hex, one record per clock, expected operands include same-cycle writeback
W 04 1234abcd
W 05 0badf00d
W 06 c0ffee06
W 00 deadbeef
D add_w     00101483 0 1000 0 0 0 0 0 0 00000000 03 04 05 0 1234abcd 0badf00d
D slti      023fec86 0 1000 0 1 4 0 0 0 fffffffb 06 04 00 0 1234abcd 00000000
D andi      037c3ca7 0 1000 0 1 9 0 0 0 00000f0f 07 05 00 0 0badf00d 00000000
D slli_w    00408c88 0 1000 0 1 e 0 0 0 00000023 08 04 00 0 1234abcd 00000000
D sra_w     001818a9 0 1000 0 0 c 0 0 0 00000000 09 05 06 0 0badf00d c0ffee06
D lu12i_w   142468aa 0 1000 1 1 0 0 0 0 12345000 0a 00 00 0 00000000 00000000
D pcaddu12i 1dffffeb 0 1000 2 1 0 0 0 0 fffff000 0b 00 00 0 00000000 00000000
D ld_b      283ff08c 0 0004 0 0 0 1 0 0 fffffffc 0c 04 00 0 1234abcd 00000000
D st_w      29802085 0 0004 0 0 6 1 0 0 00000008 00 04 05 0 1234abcd 0badf00d
D ll_w      2000088d 0 2004 0 0 2 1 1 0 00000008 0d 04 00 0 1234abcd 00000000
D sc_w      21fffc86 0 2004 0 0 6 1 1 0 fffffffc 06 04 06 0 1234abcd c0ffee06
D beq       5bfff885 0 0001 0 0 6 0 0 0 fffffffe 00 04 05 0 1234abcd 0badf00d
D bl        54040000 0 0001 0 0 5 0 0 0 00000100 01 00 00 0 00000000 00000000
D b_back    53ffffff 0 0001 0 0 4 0 0 0 ffffffff 00 00 00 0 00000000 00000000
D syscall   002b0000 0 0200 0 0 0 0 0 0 00000000 00 00 00 1 00000000 00000000
D break     002a0000 0 0200 0 0 0 0 0 0 00000000 00 00 00 2 00000000 00000000
D zero_word 00000000 0 0000 0 0 0 0 0 0 00000000 00 00 00 3 00000000 00000000
D bad_alu   00109483 0 1000 0 0 1 0 0 0 00000000 03 04 05 3 1234abcd 0badf00d
D bceqz     48000000 0 0001 0 0 2 0 0 0 00000000 00 00 00 3 00000000 00000000
D csrrd_u   0400140e 3 0010 0 0 0 0 0 1 00000005 0e 00 0e 4 00000000 00000000
D csrrd_k   0400140e 0 0010 0 0 0 0 0 1 00000005 0e 00 0e 0 00000000 00000000
D ertn_u    06483800 3 0080 0 0 0 0 0 1 00000000 00 00 00 4 00000000 00000000
D ertn_k    06483800 0 0080 0 0 0 0 0 1 00000000 00 00 00 0 00000000 00000000
D add_r0    00101403 0 1000 0 0 0 0 0 0 00000000 03 00 05 0 00000000 0badf00d
D add_byp   001010e3 0 1000 0 0 0 0 0 0 00000000 03 07 04 0 77777777 1234abcd
W 07 77777777
D add_r7    001000e3 0 1000 0 0 0 0 0 0 00000000 03 07 00 0 77777777 00000000
